/* files.f */
+incdir+design
design/div_pkg.sv
design/div_seq_if.sv
design/div_ctrl.sv
design/div_step_counter.sv
design/div_datapath.sv
design/div_unit.sv
design/div_dual_top.sv
verif/tb_div_dual.sv

/* verif/tb_div_dual.sv */
`timescale 1ns/1ps
`include "div_cfg.svh"

module tb_div_dual;

    localparam int N_OPS       = 224;              // 4 single + 16 corner + 4 burst + 200 stress
    localparam int CYCLE_LIMIT = N_OPS * 40 + 200;
    localparam int LATENCY     = `DIV_XLEN + 1;    // accepting sample to result sample

    logic                       clk;
    logic                       rst_n;
    logic                       prv_valid;
    logic                       prv_ready;
    div_pkg::div_op_e           op;
    logic [`DIV_XLEN-1:0]       rs1_value;
    logic [`DIV_XLEN-1:0]       rs2_value;
    logic [`DIV_ROB_ID_W-1:0]   rob_id;
    logic [`DIV_RD_ARCH_W-1:0]  rd_arch;
    logic [`DIV_RD_PHY_W-1:0]   rd_phy;
    logic                       nxt_valid;
    logic [`DIV_ROB_ID_W-1:0]   cdb_rob_id;
    logic [`DIV_RD_ARCH_W-1:0]  cdb_rd_arch;
    logic [`DIV_RD_PHY_W-1:0]   cdb_rd_phy;
    logic [`DIV_XLEN-1:0]       cdb_rd_value;

    integer seed = 32'h257;
    int     cycle, errors, pass_tests, fail_tests, test_errors;
    int     accepted, results, max_inflight;
    logic   saw_stall;
    logic [31:0] exp_value_q[$];
    logic [15:0] exp_tag_q[$];                     // {rob_id, rd_arch, rd_phy}
    int          accept_cycle_q[$];
    logic [31:0] exp_value;
    logic [15:0] exp_tag;
    int          accept_cycle;
    div_pkg::div_op_e op_list[4] = '{div_pkg::DIV, div_pkg::DIVU, div_pkg::REM, div_pkg::REMU};

    div_dual_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .prv_valid    (prv_valid),
        .prv_ready    (prv_ready),
        .op           (op),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .rob_id       (rob_id),
        .rd_arch      (rd_arch),
        .rd_phy       (rd_phy),
        .nxt_valid    (nxt_valid),
        .cdb_rob_id   (cdb_rob_id),
        .cdb_rd_arch  (cdb_rd_arch),
        .cdb_rd_phy   (cdb_rd_phy),
        .cdb_rd_value (cdb_rd_value)
    );

    always #4 clk = ~clk;   // 8 ns period

    // ------------------------------------------------------------
    // reference model, RISC-V M extension divide rules
    // ------------------------------------------------------------
    function automatic logic [31:0] model_result(input div_pkg::div_op_e f_op,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sres;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic               overflow;
        sa       = {{32{a[31]}}, a};
        sb       = {{32{b[31]}}, b};
        ua       = {32'b0, a};
        ub       = {32'b0, b};
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (f_op)
            div_pkg::DIV: begin
                if (b == 0) return 32'hffff_ffff;
                if (overflow) return 32'h8000_0000;
                sres = sa / sb;
                return sres[31:0];
            end
            div_pkg::DIVU: begin
                if (b == 0) return 32'hffff_ffff;
                return 32'(ua / ub);
            end
            div_pkg::REM: begin
                if (b == 0) return a;
                if (overflow) return 32'h0;
                sres = sa % sb;   // sign follows the dividend
                return sres[31:0];
            end
            default: begin
                if (b == 0) return a;
                return 32'(ua % ub);
            end
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s actual=%h expected=%h", name, actual, expected);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // monitor and scoreboard, sampled on the rising edge
    // ------------------------------------------------------------
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d results still outstanding",
                     cycle, exp_value_q.size());
            $display("Some tests failed");
            $finish;
        end else if (rst_n) begin
            if (prv_valid && prv_ready) begin
                exp_value_q.push_back(model_result(op, rs1_value, rs2_value));
                exp_tag_q.push_back({rob_id, rd_arch, rd_phy});
                accept_cycle_q.push_back(cycle);
                accepted++;
            end
            if (prv_valid && !prv_ready) saw_stall = 1'b1;
            if (nxt_valid) begin
                results++;
                if (exp_value_q.size() == 0) begin
                    $display("result strobe seen with no operation outstanding");
                    errors++;
                end else begin
                    exp_value    = exp_value_q.pop_front();
                    exp_tag      = exp_tag_q.pop_front();
                    accept_cycle = accept_cycle_q.pop_front();
                    check_value("cdb_rd_value", cdb_rd_value, exp_value);
                    check_value("cdb_rob_id", cdb_rob_id, exp_tag[15:11]);
                    check_value("cdb_rd_arch", cdb_rd_arch, exp_tag[10:6]);
                    check_value("cdb_rd_phy", cdb_rd_phy, exp_tag[5:0]);
                    check_value("latency", cycle - accept_cycle, LATENCY);
                end
            end
            if (exp_value_q.size() > max_inflight) max_inflight = exp_value_q.size();
        end
    end

    // ------------------------------------------------------------
    // driver tasks, all start and end on a falling edge
    // ------------------------------------------------------------
    task automatic issue_op(input div_pkg::div_op_e f_op, input logic [31:0] a,
                            input logic [31:0] b);
        prv_valid = 1'b1;
        op        = f_op;
        rs1_value = a;
        rs2_value = b;
        rob_id    = $random(seed);
        rd_arch   = $random(seed);
        rd_phy    = $random(seed);
        do @(posedge clk); while (!prv_ready);   // hold until a unit takes it
        @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        prv_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_drain();
        int n;
        prv_valid = 1'b0;
        n         = 0;
        // two results at most in flight, each within one latency
        while (exp_value_q.size() != 0 && n < 2 * LATENCY) begin
            @(negedge clk);
            n++;
        end
        check_value("queue_size", exp_value_q.size(), 0);
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors) begin
            pass_tests++;
            $display("test %s ok", name);
        end else begin
            fail_tests++;
            $display("test %s failed with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        prv_valid    = 1'b0;
        op           = div_pkg::DIV;
        rs1_value    = '0;
        rs2_value    = '0;
        rob_id       = '0;
        rd_arch      = '0;
        rd_phy       = '0;
        cycle        = 0;
        errors       = 0;
        test_errors  = 0;
        pass_tests   = 0;
        fail_tests   = 0;
        accepted     = 0;
        results      = 0;
        max_inflight = 0;
        saw_stall    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_value("nxt_valid", nxt_valid, 1'b0);
        check_value("prv_ready", prv_ready, 1'b1);
        finish_test("reset");

        foreach (op_list[i]) begin
            issue_op(op_list[i], $random(seed), $random(seed));
            wait_drain();
            idle_cycles(2);
        end
        finish_test("single");

        foreach (op_list[i]) begin
            issue_op(op_list[i], $random(seed), 32'h0);              // divide by zero
            issue_op(op_list[i], 32'h8000_0000, 32'hffff_ffff);    // signed overflow
            issue_op(op_list[i], 32'h0, $random(seed));
            issue_op(op_list[i], 32'hffff_ffff, $random(seed) | 1);
            idle_cycles(1);
        end
        wait_drain();
        finish_test("corner");

        // prv_valid stays high across the burst
        saw_stall    = 1'b0;
        max_inflight = 0;
        repeat (4) begin
            issue_op(op_list[$unsigned($random(seed)) % 4], $random(seed), $random(seed));
        end
        wait_drain();
        check_value("in_flight", max_inflight, 2);
        check_value("prv_ready_stall", saw_stall, 1'b1);
        finish_test("burst");

        accepted = 0;
        results  = 0;
        repeat (200) begin
            issue_op(op_list[$unsigned($random(seed)) % 4], $random(seed),
                     ($random(seed) & 4) ? ($random(seed) & 32'hff) : $random(seed));
            idle_cycles($unsigned($random(seed)) % 4);
        end
        wait_drain();
        idle_cycles(4);
        check_value("results", results, accepted);
        finish_test("stress");

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 pass_tests, fail_tests, errors);
        if (fail_tests == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* design/div_dual_top.sv */
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_dual_top (
    input  logic                       clk,
    input  logic                       rst_n,

    // issue side
    input  logic                       prv_valid,
    output logic                       prv_ready,
    input  div_pkg::div_op_e           op,
    input  logic [`DIV_XLEN-1:0]       rs1_value,
    input  logic [`DIV_XLEN-1:0]       rs2_value,
    input  logic [`DIV_ROB_ID_W-1:0]   rob_id,
    input  logic [`DIV_RD_ARCH_W-1:0]  rd_arch,
    input  logic [`DIV_RD_PHY_W-1:0]   rd_phy,

    // result bus, no back-pressure
    output logic                       nxt_valid,
    output logic [`DIV_ROB_ID_W-1:0]   cdb_rob_id,
    output logic [`DIV_RD_ARCH_W-1:0]  cdb_rd_arch,
    output logic [`DIV_RD_PHY_W-1:0]   cdb_rd_phy,
    output logic [`DIV_XLEN-1:0]       cdb_rd_value
);

    div_pkg::div_req_t  req;
    div_pkg::div_cdb_t  res_1, res_2, cdb;
    logic               valid_1, valid_2;
    logic               ready_1, ready_2;
    logic               done_1, done_2;

    assign req.op        = op;
    assign req.rs1_value = rs1_value;
    assign req.rs2_value = rs2_value;
    assign req.rob_id    = rob_id;
    assign req.rd_arch   = rd_arch;
    assign req.rd_phy    = rd_phy;

    // ------------------------------------------------------------
    // dispatch, unit 1 first
    // ------------------------------------------------------------
    assign valid_1   = prv_valid;
    assign valid_2   = prv_valid && !ready_1;
    assign prv_ready = ready_1 || ready_2;

    div_unit div_unit_1_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (valid_1),
        .req_ready (ready_1),
        .req       (req),
        .res_valid (done_1),
        .res       (res_1)
    );

    div_unit div_unit_2_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (valid_2),
        .req_ready (ready_2),
        .req       (req),
        .res_valid (done_2),
        .res       (res_2)
    );

    // fixed latency keeps the two strobes apart
    assign nxt_valid    = done_1 || done_2;
    assign cdb          = done_1 ? res_1 : res_2;
    assign cdb_rob_id   = cdb.rob_id;
    assign cdb_rd_arch  = cdb.rd_arch;
    assign cdb_rd_phy   = cdb.rd_phy;
    assign cdb_rd_value = cdb.rd_value;

endmodule

/* design/div_unit.sv */
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    output logic               req_ready,
    input  div_pkg::div_req_t  req,
    output logic               res_valid,
    output div_pkg::div_cdb_t  res
);

    div_seq_if seq ();

    logic [`DIV_ROB_ID_W-1:0]   rob_id_q;
    logic [`DIV_RD_ARCH_W-1:0]  rd_arch_q;
    logic [`DIV_RD_PHY_W-1:0]   rd_phy_q;
    logic [`DIV_XLEN-1:0]       rd_value;

    // ------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------
    div_ctrl div_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .seq       (seq)
    );

    div_step_counter div_step_counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .seq   (seq)
    );

    div_datapath div_datapath_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .seq      (seq),
        .rd_value (rd_value)
    );

    // tag rides along until the strobe
    always_ff @(posedge clk) begin
        if (seq.load) begin
            rob_id_q  <= req.rob_id;
            rd_arch_q <= req.rd_arch;
            rd_phy_q  <= req.rd_phy;
        end
    end

    assign res_valid    = seq.done;
    assign res.rob_id   = rob_id_q;
    assign res.rd_arch  = rd_arch_q;
    assign res.rd_phy   = rd_phy_q;
    assign res.rd_value = rd_value;

endmodule

/* design/div_datapath.sv */
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  div_pkg::div_req_t      req,
    div_seq_if.datapath            seq,
    output logic [`DIV_XLEN-1:0]   rd_value
);

    localparam int XLEN = `DIV_XLEN;

    div_pkg::div_op_e  op_q;
    logic              dvd_neg_q;    // dividend sign, signed ops only
    logic              dvs_neg_q;    // divisor sign, signed ops only
    logic              dvs_zero_q;

    logic [XLEN-1:0]   rs1_q;        // original dividend for REM by zero
    logic [XLEN-1:0]   dvs_q;        // divisor magnitude
    logic [XLEN-1:0]   quo_q;        // dividend bits out the top, quotient bits in
    logic [XLEN-1:0]   rem_q;        // partial remainder

    logic              is_signed;
    logic              dvd_neg;
    logic              dvs_neg;
    logic [XLEN-1:0]   dvd_mag;
    logic [XLEN-1:0]   dvs_mag;
    logic [XLEN:0]     rem_shift;
    logic [XLEN:0]     diff;
    logic [XLEN-1:0]   quo_fix;
    logic [XLEN-1:0]   rem_fix;

    // ------------------------------------------------------------
    // operand preparation
    // ------------------------------------------------------------
    assign is_signed = (req.op == div_pkg::DIV) || (req.op == div_pkg::REM);
    assign dvd_neg   = is_signed && req.rs1_value[XLEN-1];
    assign dvs_neg   = is_signed && req.rs2_value[XLEN-1];
    assign dvd_mag   = dvd_neg ? -req.rs1_value : req.rs1_value;
    assign dvs_mag   = dvs_neg ? -req.rs2_value : req.rs2_value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q       <= div_pkg::DIV;
            dvd_neg_q  <= 1'b0;
            dvs_neg_q  <= 1'b0;
            dvs_zero_q <= 1'b0;
        end else if (seq.load) begin
            op_q       <= req.op;
            dvd_neg_q  <= dvd_neg;
            dvs_neg_q  <= dvs_neg;
            dvs_zero_q <= (req.rs2_value == '0);
        end
    end

    // ------------------------------------------------------------
    // restoring shift-subtract, one bit per step
    // ------------------------------------------------------------
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign diff      = rem_shift - {1'b0, dvs_q};   // msb set means it went negative

    always_ff @(posedge clk) begin
        if (seq.load) begin
            rs1_q <= req.rs1_value;
            dvs_q <= dvs_mag;
            quo_q <= dvd_mag;
            rem_q <= '0;
        end else if (seq.step) begin
            rem_q <= diff[XLEN] ? rem_shift[XLEN-1:0] : diff[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], ~diff[XLEN]};
        end
    end

    // ------------------------------------------------------------
    // sign and divide by zero correction
    // ------------------------------------------------------------
    assign quo_fix = (dvd_neg_q ^ dvs_neg_q) ? -quo_q : quo_q;
    assign rem_fix = dvd_neg_q ? -rem_q : rem_q;   // remainder follows dividend

    always_comb begin
        case (op_q)
            div_pkg::DIV, div_pkg::DIVU: begin
                rd_value = dvs_zero_q ? '1 : quo_fix;
            end
            default: begin
                rd_value = dvs_zero_q ? rs1_q : rem_fix;
            end
        endcase
    end

endmodule

/* design/div_step_counter.sv */
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_step_counter (
    input  logic        clk,
    input  logic        rst_n,
    div_seq_if.counter  seq
);

    logic [`DIV_CNT_W-1:0] count;   // quotient bits still to produce

    // loaded with the full width, one bit per step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (seq.load) begin
            count <= `DIV_CNT_W'(`DIV_XLEN);
        end else if (seq.step) begin
            count <= count - 1'b1;
        end
    end

    // high during the final BUSY cycle
    assign seq.last = (count == `DIV_CNT_W'(1));

endmodule

/* design/div_ctrl.sv */
`timescale 1ns/1ps

module div_ctrl (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    output logic        req_ready,
    div_seq_if.ctrl     seq
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        DONE = 2'd2
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   accept;

    // ------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------
    assign req_ready = (state != BUSY);   // free in IDLE and DONE
    assign accept    = req_valid && req_ready;

    assign seq.load = accept;
    assign seq.step = (state == BUSY);
    assign seq.done = (state == DONE);    // single cycle, DONE never holds

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = BUSY;
                end
            end
            BUSY: begin
                if (seq.step && seq.last) begin
                    state_nxt = DONE;  // last quotient bit lands on this edge
                end
            end
            DONE: begin
                // back to back issue skips IDLE
                if (accept) begin
                    state_nxt = BUSY;
                end else begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

/* design/div_seq_if.sv */
`timescale 1ns/1ps

// sequencing strobes shared by the controller, the counter and the datapath
interface div_seq_if;

    logic load;   // request accepted this cycle
    logic step;   // one quotient bit per cycle
    logic last;   // final iteration
    logic done;   // result strobe

    modport ctrl (
        output load,
        output step,
        output done,
        input  last
    );

    modport counter (
        input  load,
        input  step,
        output last
    );

    modport datapath (
        input  load,
        input  step
    );

endinterface

/* design/div_pkg.sv */
`include "div_cfg.svh"

package div_pkg;

    // ------------------------------------------------------------
    // operation encoding
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        DIV  = 2'd0,   // signed quotient
        DIVU = 2'd1,   // unsigned quotient
        REM  = 2'd2,   // signed remainder
        REMU = 2'd3    // unsigned remainder
    } div_op_e;

    // ------------------------------------------------------------
    // issue side request
    // ------------------------------------------------------------
    typedef struct packed {
        div_op_e                    op;
        logic [`DIV_XLEN-1:0]       rs1_value;  // dividend
        logic [`DIV_XLEN-1:0]       rs2_value;  // divisor
        logic [`DIV_ROB_ID_W-1:0]   rob_id;
        logic [`DIV_RD_ARCH_W-1:0]  rd_arch;
        logic [`DIV_RD_PHY_W-1:0]   rd_phy;
    } div_req_t;

    // ------------------------------------------------------------
    // result bus payload
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`DIV_ROB_ID_W-1:0]   rob_id;
        logic [`DIV_RD_ARCH_W-1:0]  rd_arch;
        logic [`DIV_RD_PHY_W-1:0]   rd_phy;
        logic [`DIV_XLEN-1:0]       rd_value;
    } div_cdb_t;

endpackage

/* design/div_cfg.svh */
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// operand and result width
`define DIV_XLEN      32

// result bus tag widths
`define DIV_ROB_ID_W  5
`define DIV_RD_ARCH_W 5
`define DIV_RD_PHY_W  6

`define DIV_CNT_W     6   // must hold DIV_XLEN

`endif
